// ==== Bender.yml ====
package:
  name: lsu_unit

sources:
  - lsu_pkg.sv
  - lsu_req_format.sv
  - lsu_load_format.sv
  - lsu_ctrl.sv
  - lsu_unit.sv
  - target: test
    files:
      - tb_lsu_unit.sv

// ==== list.f ====
lsu_pkg.sv
lsu_req_format.sv
lsu_load_format.sv
lsu_ctrl.sv
lsu_unit.sv
tb_lsu_unit.sv

// ==== lsu_ctrl.sv ====
// LSU controller: dispatch acceptance, fence stall, load wait and the commit record register
`default_nettype none

module lsu_ctrl (
    input  logic                clk,
    input  logic                reset,

    input  logic                dispatch_valid,
    input  lsu_pkg::lsu_op_e    dispatch_op,
    input  lsu_pkg::lane_mask_t dispatch_tmask,
    input  logic [4:0]          dispatch_rd,
    output logic                dispatch_ready,

    input  lsu_pkg::lane_align_t req_align,

    output logic                mem_req_valid,
    output logic                mem_req_rw,
    output lsu_pkg::lane_mask_t mem_req_mask,
    input  logic                mem_req_ready,

    input  logic                mem_rsp_valid,
    input  logic                mem_busy,

    output lsu_pkg::lsu_op_e     load_op,
    output lsu_pkg::lane_align_t load_align,
    input  lsu_pkg::lane_word_t  load_data,

    output logic                commit_valid,
    output logic                commit_wb,
    output logic [4:0]          commit_rd,
    output lsu_pkg::lane_mask_t commit_tmask,
    output lsu_pkg::lane_word_t commit_data,
    input  logic                commit_ready
);
    import lsu_pkg::*;

    lsu_state_e state;

    logic is_fence;
    logic is_load;
    logic is_store;
    logic idle;
    logic dispatch_fire;
    logic rsp_take;

    assign is_fence = (dispatch_op == op_fence);
    assign is_load  = dispatch_op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign is_store = dispatch_op inside {op_sb, op_sh, op_sw};
    assign idle     = (state == st_idle);

    // fences wait for memory to drain, everything else for the request slot
    assign dispatch_ready = dispatch_valid && idle && (is_fence ? ~mem_busy : mem_req_ready);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    assign mem_req_valid = dispatch_valid && idle && ~is_fence;
    assign mem_req_rw    = is_store;
    assign mem_req_mask  = dispatch_tmask;

    assign rsp_take     = mem_rsp_valid && (state == st_load_wait);
    assign commit_valid = (state == st_commit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (dispatch_fire) begin
                        state <= is_load ? st_load_wait : st_commit;
                    end
                end
                st_load_wait: begin
                    if (mem_rsp_valid) begin
                        state <= st_commit;
                    end
                end
                st_commit: begin
                    if (commit_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // record payload, steered by the same events as the FSM
    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            commit_rd    <= dispatch_rd;
            commit_tmask <= dispatch_tmask;
            commit_wb    <= is_load;
            load_op      <= dispatch_op;
            load_align   <= req_align;
            if (!is_load) begin
                commit_data <= '0;
            end
        end
        if (rsp_take) begin
            commit_data <= load_data;
        end
    end

    // only one load outstanding, so a response is only legal while waiting
    a_rsp_in_wait : assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (state == st_load_wait)
    ) else $error("unexpected memory response in state %s", state.name());

    a_commit_hold : assert property (
        @(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_data) && $stable(commit_wb)
             && $stable(commit_rd) && $stable(commit_tmask))
    ) else $error("commit record changed under back-pressure");

endmodule

`default_nettype wire

// ==== lsu_load_format.sv ====
// load formatter: per-lane byte or half-word select with sign or zero extension, combinational
`default_nettype none

module lsu_load_format (
    input  lsu_pkg::lsu_op_e    load_op,
    input  lsu_pkg::lane_align_t load_align,
    input  lsu_pkg::lane_word_t mem_rsp_data,
    output lsu_pkg::lane_word_t load_data
);
    import lsu_pkg::*;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [xlen-1:0] data32;
        logic [15:0]     data16;
        logic [7:0]      data8;
        logic [xlen-1:0] result;

        assign data32 = mem_rsp_data[i];

        // half first, then byte within it
        assign data16 = load_align[i][1] ? data32[31:16] : data32[15:0];
        assign data8  = load_align[i][0] ? data16[15:8] : data16[7:0];

        always_comb begin
            case (load_op)
                op_lb:   result = {{(xlen-8){data8[7]}}, data8};
                op_lh:   result = {{(xlen-16){data16[15]}}, data16};
                op_lbu:  result = {{(xlen-8){1'b0}}, data8};
                op_lhu:  result = {{(xlen-16){1'b0}}, data16};
                // lw passes through
                default: result = data32;
            endcase
        end

        assign load_data[i] = result;
    end

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
// shared widths, opcode and state enums and lane array types; import into every LSU module
`default_nettype none

package lsu_pkg;

    localparam int xlen           = 32;
    localparam int num_lanes      = 2;
    localparam int byte_lanes     = xlen / 8;
    localparam int align_bits     = $clog2(byte_lanes);
    localparam int word_addr_bits = xlen - align_bits;

    // bit 3 marks stores, bit 2 unsigned loads, low bits the size
    typedef enum logic [3:0] {
        op_lb    = 4'b0000,
        op_lh    = 4'b0001,
        op_lw    = 4'b0010,
        op_lbu   = 4'b0100,
        op_lhu   = 4'b0101,
        op_sb    = 4'b1000,
        op_sh    = 4'b1001,
        op_sw    = 4'b1010,
        op_fence = 4'b1111
    } lsu_op_e;

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_load_wait = 2'd1,
        st_commit    = 2'd2
    } lsu_state_e;

    // per-lane bundles
    typedef logic [num_lanes-1:0][xlen-1:0]           lane_word_t;
    typedef logic [num_lanes-1:0][word_addr_bits-1:0] lane_waddr_t;
    typedef logic [num_lanes-1:0][byte_lanes-1:0]     lane_byteen_t;
    typedef logic [num_lanes-1:0][align_bits-1:0]     lane_align_t;
    typedef logic [num_lanes-1:0]                     lane_mask_t;

endpackage

`default_nettype wire

// ==== lsu_req_format.sv ====
// request formatter: per-lane address add, byte enables and store data alignment, combinational
`default_nettype none

module lsu_req_format (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 dispatch_valid,
    input  lsu_pkg::lsu_op_e     dispatch_op,
    input  lsu_pkg::lane_mask_t  dispatch_tmask,
    input  lsu_pkg::lane_word_t  dispatch_rs1,
    input  lsu_pkg::lane_word_t  dispatch_rs2,
    input  logic [31:0]          dispatch_imm,

    output lsu_pkg::lane_waddr_t  mem_req_addr,
    output lsu_pkg::lane_byteen_t mem_req_byteen,
    output lsu_pkg::lane_word_t   mem_req_data,
    output lsu_pkg::lane_align_t  req_align
);
    import lsu_pkg::*;

    // 0 byte, 1 half-word, 2 word
    logic [1:0] access_size;

    always_comb begin
        case (dispatch_op)
            op_lb, op_lbu, op_sb: access_size = 2'd0;
            op_lh, op_lhu, op_sh: access_size = 2'd1;
            default:              access_size = 2'd2;
        endcase
    end

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [xlen-1:0]       full_addr;
        logic [align_bits-1:0] align;
        logic [byte_lanes-1:0] byteen;
        logic                  aligned;

        assign full_addr = dispatch_rs1[i] + dispatch_imm;
        assign align     = full_addr[align_bits-1:0];

        assign mem_req_addr[i] = full_addr[xlen-1:align_bits];
        assign req_align[i]    = align;

        always_comb begin
            byteen = '0;
            if (dispatch_op != op_fence) begin
                case (access_size)
                    2'd0: byteen[align] = 1'b1;
                    2'd1: begin
                        byteen[{align[1], 1'b0}] = 1'b1;
                        byteen[{align[1], 1'b1}] = 1'b1;
                    end
                    default: byteen = '1;
                endcase
            end
        end

        assign mem_req_byteen[i] = byteen;

        // data moves up to the addressed byte
        assign mem_req_data[i] = dispatch_rs2[i] << {align, 3'b000};

        always_comb begin
            case (access_size)
                2'd0:    aligned = 1'b1;
                2'd1:    aligned = ~align[0];
                default: aligned = (align == '0);
            endcase
        end

        // no misaligned accesses on any active lane
        a_aligned : assert property (
            @(posedge clk) disable iff (reset)
            (dispatch_valid && dispatch_tmask[i] && dispatch_op != op_fence) |-> aligned
        ) else $error("misaligned access on lane %0d, addr=0x%08h", i, full_addr);
    end

endmodule

`default_nettype wire

// ==== lsu_unit.sv ====
// LSU top level: controller plus request and load formatters, one memory operation in flight
`default_nettype none

module lsu_unit (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  lsu_pkg::lsu_op_e      dispatch_op,
    input  lsu_pkg::lane_mask_t   dispatch_tmask,
    input  logic [4:0]            dispatch_rd,
    input  lsu_pkg::lane_word_t   dispatch_rs1,
    input  lsu_pkg::lane_word_t   dispatch_rs2,
    input  logic [31:0]           dispatch_imm,

    output logic                  mem_req_valid,
    output logic                  mem_req_rw,
    output lsu_pkg::lane_mask_t   mem_req_mask,
    output lsu_pkg::lane_waddr_t  mem_req_addr,
    output lsu_pkg::lane_byteen_t mem_req_byteen,
    output lsu_pkg::lane_word_t   mem_req_data,
    input  logic                  mem_req_ready,

    input  logic                  mem_rsp_valid,
    input  lsu_pkg::lane_word_t   mem_rsp_data,
    input  logic                  mem_busy,

    output logic                  commit_valid,
    output logic                  commit_wb,
    output logic [4:0]            commit_rd,
    output lsu_pkg::lane_mask_t   commit_tmask,
    output lsu_pkg::lane_word_t   commit_data,
    input  logic                  commit_ready
);
    import lsu_pkg::*;

    lane_align_t req_align;
    lsu_op_e     load_op;
    lane_align_t load_align;
    lane_word_t  load_data;

    lsu_req_format u_req_format (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tmask (dispatch_tmask),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_rs2   (dispatch_rs2),
        .dispatch_imm   (dispatch_imm),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .req_align      (req_align)
    );

    lsu_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_op    (dispatch_op),
        .dispatch_tmask (dispatch_tmask),
        .dispatch_rd    (dispatch_rd),
        .dispatch_ready (dispatch_ready),
        .req_align      (req_align),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_mask   (mem_req_mask),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_busy       (mem_busy),
        .load_op        (load_op),
        .load_align     (load_align),
        .load_data      (load_data),
        .commit_valid   (commit_valid),
        .commit_wb      (commit_wb),
        .commit_rd      (commit_rd),
        .commit_tmask   (commit_tmask),
        .commit_data    (commit_data),
        .commit_ready   (commit_ready)
    );

    // formats the raw response with the captured op and offsets
    lsu_load_format u_load_format (
        .load_op      (load_op),
        .load_align   (load_align),
        .mem_rsp_data (mem_rsp_data),
        .load_data    (load_data)
    );

endmodule

`default_nettype wire

// ==== tb_lsu_unit.sv ====
// testbench for lsu_unit: table of stores, loads and a fence against a 16-word memory model
`default_nettype none

module tb_lsu_unit;
    import lsu_pkg::*;

    localparam int reset_cycles = 16;
    localparam logic [31:0] data_a = 32'hdeadbeef;
    localparam logic [31:0] data_b = 32'h13572468;

    logic         clk;
    logic         reset;
    logic         dispatch_valid, dispatch_ready, dispatch_fire;
    lsu_op_e      dispatch_op;
    lane_mask_t   dispatch_tmask;
    logic [4:0]   dispatch_rd;
    lane_word_t   dispatch_rs1, dispatch_rs2;
    logic [31:0]  dispatch_imm;
    logic         mem_req_valid, mem_req_rw, mem_req_ready;
    lane_mask_t   mem_req_mask;
    lane_waddr_t  mem_req_addr;
    lane_byteen_t mem_req_byteen;
    lane_word_t   mem_req_data;
    logic         mem_rsp_valid;
    lane_word_t   mem_rsp_data;
    logic         mem_busy, rand_busy, fence_busy;
    logic         commit_valid, commit_wb, commit_ready;
    logic [4:0]   commit_rd;
    lane_mask_t   commit_tmask;
    lane_word_t   commit_data;
    logic [72:0]  record;

    logic [31:0] mem [16];
    lane_word_t  rsp_word;
    logic        rsp_pending, expect_commit, held, was_valid, in_flight;
    logic [72:0] held_record;
    int          rsp_delay, busy_left, cycles, limit, errors, passed, failed;

    // stimulus table, one entry per index
    lsu_op_e     t_op[$];
    lane_mask_t  t_mask[$];
    logic [4:0]  t_rd[$];
    lane_word_t  t_rs1[$], t_rs2[$], t_exp[$];
    logic [31:0] t_imm[$];

    lsu_unit u_dut (.*);

    assign mem_busy      = rand_busy | fence_busy;
    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign record        = {commit_valid, commit_wb, commit_rd, commit_tmask, commit_data};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_entry(input lsu_op_e op, input lane_mask_t mask, input logic [4:0] rd,
                             input logic [31:0] rs1_a, rs1_b, rs2_a, rs2_b, imm, exp_a, exp_b);
        t_op.push_back(op);
        t_mask.push_back(mask);
        t_rd.push_back(rd);
        t_rs1.push_back({rs1_b, rs1_a});
        t_rs2.push_back({rs2_b, rs2_a});
        t_imm.push_back(imm);
        t_exp.push_back({exp_b, exp_a});
    endtask

    task automatic offer_entry(input int i);
        dispatch_valid = 1'b1;
        dispatch_op    = t_op[i];
        dispatch_tmask = t_mask[i];
        dispatch_rd    = t_rd[i];
        dispatch_rs1   = t_rs1[i];
        dispatch_rs2   = t_rs2[i];
        dispatch_imm   = t_imm[i];
        // hold memory busy so the fence has to wait
        fence_busy     = (t_op[i] == op_fence);
    endtask

    task automatic report_mismatch(input string name, input logic [79:0] exp,
                                   input logic [79:0] act);
        $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t: %s", $time, what);
        errors++;
    endtask

    // byte j of word n is {n, 2'b10, j}
    function automatic logic [31:0] fill_word(input logic [3:0] n);
        return {n, 4'hb, n, 4'ha, n, 4'h9, n, 4'h8};
    endfunction

    // memory model, stalls and commit back-pressure, all driven on the falling edge
    always @(negedge clk) begin
        mem_req_ready = ($urandom % 4) != 0;
        commit_ready  = ($urandom % 3) != 0;
        if (busy_left > 0)
            busy_left--;
        else if ($urandom % 8 == 0)
            busy_left = 1 + $urandom % 3;
        rand_busy     = (busy_left != 0);
        mem_rsp_valid = 1'b0;
        if (rsp_pending) begin
            rsp_delay   = 1 + $urandom % 4;
            rsp_pending = 1'b0;
        end
        if (rsp_delay > 0) begin
            rsp_delay--;
            if (rsp_delay == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_word;
            end
        end
    end

    // checks on pre-edge values, plus memory writes and read capture
    always @(posedge clk) begin
        if (!reset) begin
            if (commit_valid && !was_valid && !expect_commit)
                report_failure("commit_valid rose without a store, fence or response before it");
            if (expect_commit && !commit_valid)
                report_mismatch("commit_valid", 1, commit_valid);
            if (held && record !== held_record)
                report_mismatch("commit record", held_record, record);
            if (dispatch_fire && in_flight)
                report_failure("dispatch accepted while another operation was in flight");
            if ((mem_req_valid && mem_req_ready) !== (dispatch_fire && dispatch_op != op_fence))
                report_failure("memory request did not transfer with its dispatch acceptance");
            if (dispatch_fire && dispatch_op == op_fence && mem_busy)
                report_failure("fence accepted while memory was busy");
            expect_commit = mem_rsp_valid ||
                            (dispatch_fire && dispatch_op inside {op_sb, op_sh, op_sw, op_fence});
            held        = commit_valid && !commit_ready;
            held_record = record;
            was_valid   = commit_valid;
            if (commit_valid && commit_ready)
                in_flight = 1'b0;
            if (dispatch_fire)
                in_flight = 1'b1;
            if (mem_req_valid && mem_req_ready) begin
                for (int l = 0; l < num_lanes; l++) begin
                    for (int b = 0; b < byte_lanes; b++) begin
                        if (mem_req_rw && mem_req_mask[l] && mem_req_byteen[l][b])
                            mem[mem_req_addr[l][3:0]][8*b +: 8] = mem_req_data[l][8*b +: 8];
                    end
                    rsp_word[l] = mem[mem_req_addr[l][3:0]];
                end
                rsp_pending = !mem_req_rw;
            end
        end
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, the LSU stopped making progress", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int          start_errors;
        logic [31:0] addr;
        logic        is_load;

        void'($urandom(32'hdf0b));
        reset       = 1'b1;
        dispatch_op = op_lb;
        {dispatch_valid, dispatch_tmask, dispatch_rd} = '0;
        {dispatch_rs1, dispatch_rs2, dispatch_imm} = '0;
        {mem_req_ready, mem_rsp_valid, mem_rsp_data, rand_busy, fence_busy} = '0;
        {commit_ready, rsp_pending, expect_commit, held, was_valid, in_flight} = '0;
        {rsp_delay, busy_left, cycles, errors, passed, failed} = '0;
        for (int n = 0; n < 16; n++)
            mem[n] = fill_word(n[3:0]);

        // op, tmask, rd, rs1 a/b, rs2 a/b, imm, expected a/b
        // stores expect the memory word afterwards, loads the commit data
        add_entry(op_sb, 2'b11, 1, 'h100, 'h120, data_a, data_b, 0, 'h0b0a09ef, 'h8b8a8968);
        add_entry(op_sb, 2'b11, 2, 'h100, 'h120, data_a, data_b, 5, 'h1b1aef18, 'h9b9a6898);
        add_entry(op_sb, 2'b11, 3, 'h100, 'h120, data_a, data_b, 10, 'h2bef2928, 'hab68a9a8);
        add_entry(op_sb, 2'b11, 4, 'h100, 'h120, data_a, data_b, 15, 'hef3a3938, 'h68bab9b8);
        add_entry(op_sh, 2'b11, 5, 'h100, 'h120, data_a, data_b, 16, 'h4b4abeef, 'hcbca2468);
        add_entry(op_sh, 2'b11, 6, 'h100, 'h120, data_a, data_b, 22, 'hbeef5958, 'h2468d9d8);
        add_entry(op_sw, 2'b11, 7, 'h100, 'h120, data_a, data_b, 24, 'hdeadbeef, 'h13572468);
        add_entry(op_sw, 2'b01, 8, 'h100, 'h120, data_a, data_b, 4, 'hdeadbeef, 'h9b9a6898);
        add_entry(op_sh, 2'b10, 9, 'h100, 'h120, data_a, data_b, 2, 'h0b0a09ef, 'h24688968);
        add_entry(op_fence, 2'b11, 0, 0, 0, 0, 0, 0, 0, 0);
        add_entry(op_lb, 2'b11, 10, 'h11c, 'h13c, 0, 0, 0, 'h00000078, 'hfffffff8);
        add_entry(op_lb, 2'b11, 11, 'h11c, 'h13c, 0, 0, 1, 'h00000079, 'hfffffff9);
        add_entry(op_lb, 2'b11, 12, 'h11c, 'h13c, 0, 0, 2, 'h0000007a, 'hfffffffa);
        add_entry(op_lb, 2'b11, 13, 'h11c, 'h13c, 0, 0, 3, 'h0000007b, 'hfffffffb);
        add_entry(op_lbu, 2'b11, 14, 'h11c, 'h13c, 0, 0, 0, 'h00000078, 'h000000f8);
        add_entry(op_lbu, 2'b11, 15, 'h11c, 'h13c, 0, 0, 1, 'h00000079, 'h000000f9);
        add_entry(op_lbu, 2'b11, 16, 'h11c, 'h13c, 0, 0, 2, 'h0000007a, 'h000000fa);
        add_entry(op_lbu, 2'b11, 17, 'h11c, 'h13c, 0, 0, 3, 'h0000007b, 'h000000fb);
        add_entry(op_lh, 2'b11, 18, 'h11c, 'h13c, 0, 0, 0, 'h00007978, 'hfffff9f8);
        add_entry(op_lh, 2'b11, 19, 'h11c, 'h13c, 0, 0, 2, 'h00007b7a, 'hfffffbfa);
        add_entry(op_lhu, 2'b11, 20, 'h11c, 'h13c, 0, 0, 0, 'h00007978, 'h0000f9f8);
        add_entry(op_lhu, 2'b11, 21, 'h11c, 'h13c, 0, 0, 2, 'h00007b7a, 'h0000fbfa);
        add_entry(op_lw, 2'b11, 22, 'h11c, 'h13c, 0, 0, 0, 'h7b7a7978, 'hfbfaf9f8);
        add_entry(op_lw, 2'b11, 23, 'h100, 'h120, 0, 0, 24, 'hdeadbeef, 'h13572468);
        add_entry(op_lh, 2'b11, 24, 'h100, 'h120, 0, 0, 22, 'hffffbeef, 'h00002468);
        add_entry(op_lb, 2'b01, 25, 'h100, 'h120, 0, 0, 23, 'hffffffbe, 0);
        limit = reset_cycles + 64 * t_op.size();

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        offer_entry(0);

        for (int i = 0; i < t_op.size(); i++) begin
            start_errors = errors;
            is_load = t_op[i] inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
            // release the fence hold after a few cycles
            if (t_op[i] == op_fence) begin
                repeat (3) @(negedge clk);
                fence_busy = 1'b0;
            end
            do begin
                @(posedge clk);
            end while (!dispatch_ready);
            // the next entry queues behind this one's commit record
            @(negedge clk);
            if (i + 1 < t_op.size())
                offer_entry(i + 1);
            else
                dispatch_valid = 1'b0;
            do begin
                @(posedge clk);
            end while (!(commit_valid && commit_ready));

            if (commit_wb !== is_load)
                report_mismatch("commit_wb", is_load, commit_wb);
            if (commit_rd !== t_rd[i])
                report_mismatch("commit_rd", t_rd[i], commit_rd);
            if (commit_tmask !== t_mask[i])
                report_mismatch("commit_tmask", t_mask[i], commit_tmask);
            if (!is_load && commit_data !== '0)
                report_mismatch("commit_data", 0, commit_data);
            for (int l = 0; l < num_lanes; l++) begin
                addr = t_rs1[i][l] + t_imm[i];
                if (is_load && t_mask[i][l] && commit_data[l] !== t_exp[i][l])
                    report_mismatch($sformatf("commit_data[%0d]", l), t_exp[i][l], commit_data[l]);
                if (t_op[i] inside {op_sb, op_sh, op_sw} && mem[addr[5:2]] !== t_exp[i][l])
                    report_mismatch($sformatf("mem[%0d]", addr[5:2]), t_exp[i][l], mem[addr[5:2]]);
            end
            @(negedge clk);
            if (errors == start_errors)
                passed++;
            else
                failed++;
            $display("test %0d %s rd=%0d: %s", i, t_op[i].name(), t_rd[i],
                     (errors == start_errors) ? "ok" : "failed");
        end

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
